//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+.
cpu_pkg.sv
cpu_alu.sv
cpu_regfile.sv
cpu_decoder.sv
cpu_sequencer.sv
cpu_top.sv
cpu_props.sv
tb_cpu.sv

//--- cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_alu (
    input  wire cpu_pkg::alu_op_e  alu_op,
    input  wire cpu_pkg::byte_t    opnd_a,
    input  wire cpu_pkg::byte_t    opnd_b,
    input  wire cpu_pkg::flags_t   flags,
    input  wire                    opcode_bit5,  // CLC=0 SEC=1
    output cpu_pkg::byte_t         result,
    output cpu_pkg::flags_t        flags_next
);

    logic           sub;     // SBC or CMP
    cpu_pkg::byte_t b_in;    // Inverted for subtract
    logic           c_in;
    logic [8:0]     sum;     // Carry out in bit 8

    assign sub  = (alu_op == cpu_pkg::ALU_SBC) || (alu_op == cpu_pkg::ALU_CMP);
    assign b_in = sub ? ~opnd_b : opnd_b;
    assign c_in = (alu_op == cpu_pkg::ALU_CMP) ? 1'b1 : flags[`FLAG_C];  // CMP ignores C
    assign sum  = {1'b0, opnd_a} + {1'b0, b_in} + {8'd0, c_in};

    // ----------------------------------------------------------
    // Result and flags
    // ----------------------------------------------------------
    always_comb begin
        flags_next = flags;
        case (alu_op)
            cpu_pkg::ALU_ORA: result = opnd_a | opnd_b;
            cpu_pkg::ALU_AND: result = opnd_a & opnd_b;
            cpu_pkg::ALU_EOR: result = opnd_a ^ opnd_b;
            cpu_pkg::ALU_ADC, cpu_pkg::ALU_SBC: begin
                result = sum[7:0];
                // Same input signs, different result sign
                flags_next[`FLAG_V] = (opnd_a[7] == b_in[7]) && (sum[7] != opnd_a[7]);
                flags_next[`FLAG_C] = sum[8];                 // SBC: no borrow
            end
            cpu_pkg::ALU_CMP: begin
                result              = sum[7:0];               // A minus operand
                flags_next[`FLAG_C] = sum[8];                 // A >= operand
            end
            cpu_pkg::ALU_INC: result = opnd_b + 8'd1;
            cpu_pkg::ALU_DEC: result = opnd_b - 8'd1;
            cpu_pkg::ALU_FLAGC: begin
                result              = opnd_b;
                flags_next[`FLAG_C] = opcode_bit5;
            end
            default: result = opnd_b;                         // Pass through
        endcase
        if (alu_op != cpu_pkg::ALU_FLAGC) begin
            flags_next[`FLAG_N] = result[7];
            flags_next[`FLAG_Z] = (result == 8'h00);
        end
    end

endmodule

`default_nettype wire

//--- cpu_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_decoder (
    input  wire cpu_pkg::ucycle_e  ucycle,
    input  wire cpu_pkg::byte_t    opcode,
    input  wire cpu_pkg::flags_t   flags,
    output cpu_pkg::alu_op_e       alu_op,
    output cpu_pkg::reg_sel_t      sel_a,
    output cpu_pkg::reg_sel_t      sel_b_reg,   // 0 = memory or A
    output logic                   use_acc,     // A instead of memory
    output logic                   reg_we,
    output logic                   flag_we,
    output cpu_pkg::reg_sel_t      wr_sel,
    output cpu_pkg::reg_sel_t      store_sel,
    output logic                   branch_taken
);

    logic             exec;       // Cycle where results are written
    cpu_pkg::alu_op_e group_op;   // From opcode bits 7:5

    assign exec = (ucycle == cpu_pkg::UC_EXEC) || (ucycle == cpu_pkg::UC_IMM);

    // STA=xx01 STX=xx10 STY=xx00
    assign store_sel = opcode[0] ? 2'd0 : (opcode[1] ? 2'd1 : 2'd2);

    // ----------------------------------------------------------
    // Branch condition
    // ----------------------------------------------------------
    always_comb begin
        case (opcode[7:6])
            2'b00:   branch_taken = (flags[`FLAG_N] == opcode[5]);  // BPL BMI
            2'b01:   branch_taken = (flags[`FLAG_V] == opcode[5]);  // BVC BVS
            2'b10:   branch_taken = (flags[`FLAG_C] == opcode[5]);  // BCC BCS
            default: branch_taken = (flags[`FLAG_Z] == opcode[5]);  // BNE BEQ
        endcase
    end

    always_comb begin
        case (opcode[7:5])
            3'b000:  group_op = cpu_pkg::ALU_ORA;
            3'b001:  group_op = cpu_pkg::ALU_AND;
            3'b010:  group_op = cpu_pkg::ALU_EOR;
            3'b011:  group_op = cpu_pkg::ALU_ADC;
            3'b110:  group_op = cpu_pkg::ALU_CMP;
            3'b111:  group_op = cpu_pkg::ALU_SBC;
            default: group_op = cpu_pkg::ALU_PASS;  // STA LDA
        endcase
    end

    // ----------------------------------------------------------
    // Control decode
    // ----------------------------------------------------------
    always_comb begin
        alu_op    = cpu_pkg::ALU_PASS;
        sel_a     = 2'd0;
        sel_b_reg = 2'd0;
        use_acc   = 1'b0;
        reg_we    = 1'b0;
        flag_we   = 1'b0;
        wr_sel    = 2'd0;
        if (exec) begin
            casez (opcode)
                8'b???_???_01: begin                              // Accumulator group
                    alu_op  = group_op;
                    reg_we  = (opcode[7:5] != 3'b100) && (opcode[7:5] != 3'b110);
                    flag_we = (opcode[7:5] != 3'b100);            // STA leaves P
                end
                `OP_LDX_IMM: {reg_we, flag_we, wr_sel} = {2'b11, 2'd1};
                `OP_LDY_IMM: {reg_we, flag_we, wr_sel} = {2'b11, 2'd2};
                `OP_TAX:     {use_acc, reg_we, flag_we, wr_sel} = {3'b111, 2'd1};
                `OP_TAY:     {use_acc, reg_we, flag_we, wr_sel} = {3'b111, 2'd2};
                `OP_TXA:     {sel_b_reg, reg_we, flag_we} = {2'd1, 2'b11};
                `OP_TYA:     {sel_b_reg, reg_we, flag_we} = {2'd2, 2'b11};
                `OP_INX, `OP_DEX: begin
                    alu_op    = opcode[5] ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
                    sel_a     = 2'd1;
                    sel_b_reg = 2'd1;
                    wr_sel    = 2'd1;
                    reg_we    = 1'b1;
                    flag_we   = 1'b1;
                end
                `OP_INY, `OP_DEY: begin
                    alu_op    = opcode[6] ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;  // C8 vs 88
                    sel_a     = 2'd2;
                    sel_b_reg = 2'd2;
                    wr_sel    = 2'd2;
                    reg_we    = 1'b1;
                    flag_we   = 1'b1;
                end
                `OP_CLC, `OP_SEC: begin                           // C from bit 5
                    alu_op  = cpu_pkg::ALU_FLAGC;
                    flag_we = 1'b1;
                end
                default: ;                                        // Stores, JMP, NOP
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ----------------------------------------------------------
// Vectors
// ----------------------------------------------------------
`define CPU_RESET_VEC  16'hFFFC   // Reset vector low byte
`define CPU_PC_INIT    16'hC000   // PC before vector load

// ----------------------------------------------------------
// Opcodes matched as whole bytes
// ----------------------------------------------------------
`define OP_JMP_ABS     8'h4C
`define OP_LDX_IMM     8'hA2
`define OP_LDY_IMM     8'hA0
`define OP_TAX         8'hAA
`define OP_TAY         8'hA8
`define OP_TXA         8'h8A
`define OP_TYA         8'h98
`define OP_INX         8'hE8
`define OP_INY         8'hC8
`define OP_DEX         8'hCA
`define OP_DEY         8'h88
`define OP_CLC         8'h18
`define OP_SEC         8'h38

// Status register bit positions
`define FLAG_N         7
`define FLAG_V         6
`define FLAG_Z         1
`define FLAG_C         0

`endif

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;     // Data byte or register value
    typedef logic [15:0] addr_t;     // Memory address or PC
    typedef logic [7:0]  flags_t;    // N V - B D I Z C
    typedef logic [1:0]  reg_sel_t;  // 0=A 1=X 2=Y 3=P

    // Microcycle of the sequencer
    typedef enum logic [3:0] {
        UC_FETCH,      // Opcode read, PC++
        UC_IMM,        // Immediate operand, executes here
        UC_ZP,         // Zero page address byte
        UC_ABS_LO,     // Absolute low byte
        UC_ABS_HI,     // Absolute high byte
        UC_EXEC,       // Execute at EA or implied
        UC_REL,        // Branch offset byte
        UC_REL_CROSS,  // Page cross penalty
        UC_REL_DONE,   // Taken branch penalty
        UC_RST_LO,     // Vector low byte
        UC_RST_HI,     // Vector high byte
        UC_RST_JMP     // Dummy cycle before first fetch
    } ucycle_e;

    // ALU operation
    typedef enum logic [3:0] {
        ALU_ORA,
        ALU_AND,
        ALU_EOR,
        ALU_ADC,
        ALU_PASS,      // LDA, STA, LDX, LDY, transfers
        ALU_CMP,
        ALU_SBC,
        ALU_INC,
        ALU_DEC,
        ALU_FLAGC      // CLC and SEC
    } alu_op_e;

endpackage

`default_nettype wire

//--- cpu_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_props (
    input  wire                    CLK,
    input  wire                    RESET,
    input  wire cpu_pkg::ucycle_e  ucycle,
    input  wire cpu_pkg::addr_t    addr,
    input  wire cpu_pkg::addr_t    waddr,
    input  wire cpu_pkg::byte_t    dout,
    input  wire                    wreq
);

    localparam int             N_STORES  = 17;
    localparam cpu_pkg::addr_t LOOP_ADDR = 16'h0304;  // Final self-jump

    int          store_idx = 0;    // Stores seen so far
    int          loop_hits = 0;    // Fetches of the self-jump
    int          since_rst = 0;    // Cycles after reset release
    int          gap       = 0;    // Cycles since last loop fetch
    int          err_count = 0;
    logic        rst_seen  = 1'b0;
    string       fail_name = "";
    logic [23:0] fail_exp;
    logic [23:0] fail_act;
    logic [39:0] exp_now;          // {address, data, next fetch} of next store

    // Store sequence worked out by hand from the program
    function automatic logic [39:0] expected_store(input int idx);
        case (idx)
            0:       return 40'h0010_5A_0204;  // LDA #5A
            1:       return 40'h0011_50_0208;  // AND #F0
            2:       return 40'h0012_5C_020C;  // ORA #0C
            3:       return 40'h0013_A3_0210;  // EOR #FF
            4:       return 40'h0014_C8_0215;  // ADC #25 with C clear
            5:       return 40'h0015_80_021A;  // SBC #48 with C set
            6:       return 40'h0016_DB_021E;  // ADC zp 10 with carry in
            7:       return 40'h0400_80_0224;  // STX after INX
            8:       return 40'h0401_02_022A;  // STY after DEY
            9:       return 40'h0402_7F_022F;  // DEX then TXA
            10:      return 40'h0403_02_0233;  // TYA
            11:      return 40'h0404_03_0238;  // TAX then INX
            12:      return 40'h0405_80_023E;  // LDA absolute
            13:      return 40'h0020_80_0243;  // BCC not taken
            14:      return 40'h0023_80_0252;  // BNE not taken
            15:      return 40'h0024_80_0258;  // BCS not taken
            16:      return 40'h0026_80_0304;  // After page-crossing BMI
            default: return 40'hFFFF_FF_FFFF;
        endcase
    endfunction

    assign exp_now = expected_store(store_idx);

    // ----------------------------------------------------------
    // Tracking state
    // ----------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            since_rst <= 0;
            store_idx <= 0;
            loop_hits <= 0;
            gap       <= 0;
            rst_seen  <= 1'b1;
        end else begin
            if (since_rst < 15) since_rst <= since_rst + 1;
            if (wreq) store_idx <= store_idx + 1;
            gap <= gap + 1;
            if (ucycle == cpu_pkg::UC_FETCH && addr == LOOP_ADDR) begin
                loop_hits <= loop_hits + 1;
                gap       <= 1;               // Restart count at loop fetch
            end
        end
    end

    // ----------------------------------------------------------
    // Checks, sampled mid-cycle
    // ----------------------------------------------------------
    assert property (@(negedge CLK) (RESET && rst_seen) |-> !wreq)
        else begin
            $error("Write strobe high during reset");
            err_count++;
            fail_name = "reset_wreq";
            fail_exp  = 24'h0;
            fail_act  = 24'(wreq);
        end

    // FFFC then FFFD then the vector twice
    assert property (@(negedge CLK) (!RESET && rst_seen && since_rst < 4) |->
        addr == (since_rst == 0 ? `CPU_RESET_VEC :
                 since_rst == 1 ? `CPU_RESET_VEC + 16'd1 : 16'h0200))
        else begin
            $error("Reset vector fetch sequence wrong");
            err_count++;
            fail_name = "reset_vector";
            fail_exp  = 24'(since_rst == 0 ? 16'hFFFC : since_rst == 1 ? 16'hFFFD : 16'h0200);
            fail_act  = 24'(addr);
        end

    assert property (@(negedge CLK) wreq |->
        (store_idx < N_STORES) && ({waddr, dout} == exp_now[39:16]))
        else begin
            $error("Store address or data wrong");
            err_count++;
            fail_name = "store";
            fail_exp  = exp_now[39:16];
            fail_act  = {waddr, dout};
        end

    // Strobe cycle is the fetch of the next instruction
    assert property (@(negedge CLK) wreq |-> addr == exp_now[15:0])
        else begin
            $error("Address during write strobe is not the next fetch");
            err_count++;
            fail_name = "strobe_fetch";
            fail_exp  = 24'(exp_now[15:0]);
            fail_act  = 24'(addr);
        end

    assert property (@(negedge CLK) (wreq && rst_seen) |-> !$past(wreq))
        else begin
            $error("Write strobe longer than one cycle");
            err_count++;
            fail_name = "strobe_width";
            fail_exp  = 24'd1;
            fail_act  = 24'd2;
        end

    assert property (@(negedge CLK) (ucycle == cpu_pkg::UC_FETCH && loop_hits > 0) |->
        (addr == LOOP_ADDR) && (gap == 3))
        else begin
            $error("Self-jump loop left or mistimed");
            err_count++;
            fail_name = "jmp_loop";
            fail_exp  = {LOOP_ADDR, 8'd3};
            fail_act  = {addr, gap[7:0]};
        end

endmodule

bind cpu_top cpu_props u_props (
    .CLK(CLK), .RESET(RESET), .ucycle(ucycle), .addr(addr),
    .waddr(waddr), .dout(dout), .wreq(wreq)
);

`default_nettype wire

//--- cpu_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_regfile (
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire cpu_pkg::byte_t     din,         // Memory operand
    input  wire cpu_pkg::reg_sel_t  sel_a,
    input  wire cpu_pkg::reg_sel_t  sel_b_reg,
    input  wire                     use_acc,
    input  wire                     reg_we,
    input  wire                     flag_we,
    input  wire cpu_pkg::reg_sel_t  wr_sel,
    input  wire cpu_pkg::reg_sel_t  store_sel,
    input  wire cpu_pkg::byte_t     result,
    input  wire cpu_pkg::flags_t    flags_next,
    output cpu_pkg::byte_t          opnd_a,
    output cpu_pkg::byte_t          opnd_b,
    output cpu_pkg::flags_t         flags,
    output cpu_pkg::byte_t          store_data
);

    cpu_pkg::byte_t  a_reg;
    cpu_pkg::byte_t  x_reg;
    cpu_pkg::byte_t  y_reg;
    cpu_pkg::flags_t p_reg;

    // A X Y P by select code
    function automatic cpu_pkg::byte_t pick(input cpu_pkg::reg_sel_t sel,
                                            input cpu_pkg::byte_t a, input cpu_pkg::byte_t x,
                                            input cpu_pkg::byte_t y, input cpu_pkg::byte_t p);
        case (sel)
            2'd0:    return a;
            2'd1:    return x;
            2'd2:    return y;
            default: return p;
        endcase
    endfunction

    assign opnd_a     = pick(sel_a, a_reg, x_reg, y_reg, p_reg);
    assign store_data = pick(store_sel, a_reg, x_reg, y_reg, p_reg);
    assign flags      = p_reg;

    always_comb begin
        case (sel_b_reg)
            2'd1:    opnd_b = x_reg;
            2'd2:    opnd_b = y_reg;
            default: opnd_b = use_acc ? a_reg : din;  // Memory unless TAx
        endcase
    end

    // ----------------------------------------------------------
    // Write back at end of exec cycle
    // ----------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            a_reg <= 8'h00;
            x_reg <= 8'h00;
            y_reg <= 8'h00;
            p_reg <= 8'h00;
        end else begin
            if (flag_we) p_reg <= flags_next;
            if (reg_we) begin
                case (wr_sel)
                    2'd0:    a_reg <= result;
                    2'd1:    x_reg <= result;
                    2'd2:    y_reg <= result;
                    default: p_reg <= result;  // Direct load wins over flags
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- cpu_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_macros.svh"

module cpu_sequencer (
    input  wire                    CLK,
    input  wire                    RESET,
    input  wire cpu_pkg::byte_t    din,           // Memory read data
    input  wire                    branch_taken,  // Branch condition met
    input  wire cpu_pkg::byte_t    store_data,    // Register picked for store
    output cpu_pkg::ucycle_e       ucycle,
    output cpu_pkg::byte_t         opcode,
    output cpu_pkg::addr_t         addr,
    output cpu_pkg::addr_t         waddr,
    output cpu_pkg::byte_t         dout,
    output logic                   wreq
);

    cpu_pkg::addr_t   pc;        // Program counter
    cpu_pkg::addr_t   ea;        // Effective address
    cpu_pkg::byte_t   tr;        // Latched low byte
    logic             am;        // 1 = address from EA

    cpu_pkg::addr_t   pc_inc;
    cpu_pkg::addr_t   pc_rel;    // Branch target
    cpu_pkg::addr_t   ea_abs;    // High byte on din, low in tr
    logic             is_store;
    cpu_pkg::ucycle_e mode;      // First cycle after fetch

    assign pc_inc   = pc + 16'd1;
    assign pc_rel   = pc_inc + {{8{din[7]}}, din};  // Signed offset
    assign ea_abs   = {din, tr};
    assign is_store = (opcode[7:5] == 3'b100) && (opcode[0] || opcode[2]); // STA STX STY

    assign addr  = (ucycle == cpu_pkg::UC_RST_LO) ? `CPU_RESET_VEC : (am ? ea : pc);
    assign waddr = ea;

    // ----------------------------------------------------------
    // Addressing mode of the byte being fetched
    // ----------------------------------------------------------
    always_comb begin
        casez (din)
            8'b???_100_00: mode = cpu_pkg::UC_REL;     // Bcc
            8'b???_010_01,                             // ALU immediate
            8'b1??_000_?0: mode = cpu_pkg::UC_IMM;     // LDX LDY immediate
            8'b???_001_??: mode = cpu_pkg::UC_ZP;
            8'b???_011_??: mode = cpu_pkg::UC_ABS_LO;  // Includes JMP
            default:       mode = cpu_pkg::UC_EXEC;    // Implied
        endcase
    end

    // ----------------------------------------------------------
    // Microcycle walk
    // ----------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            ucycle <= cpu_pkg::UC_RST_LO;
            pc     <= `CPU_PC_INIT;
            am     <= 1'b0;
            wreq   <= 1'b0;
        end else begin
            case (ucycle)
                cpu_pkg::UC_FETCH: begin
                    opcode <= din;
                    pc     <= pc_inc;
                    wreq   <= 1'b0;               // Strobe lasts one cycle
                    ucycle <= mode;
                end
                cpu_pkg::UC_IMM: begin            // Regfile writes at this edge
                    pc     <= pc_inc;
                    ucycle <= cpu_pkg::UC_FETCH;
                end
                cpu_pkg::UC_ZP: begin
                    pc     <= pc_inc;
                    ea     <= {8'h00, din};
                    am     <= 1'b1;
                    ucycle <= cpu_pkg::UC_EXEC;
                end
                cpu_pkg::UC_ABS_LO: begin
                    tr     <= din;
                    pc     <= pc_inc;
                    ucycle <= cpu_pkg::UC_ABS_HI;
                end
                cpu_pkg::UC_ABS_HI: begin
                    if (opcode == `OP_JMP_ABS) begin
                        pc     <= ea_abs;         // Jump done in 3 cycles
                        ucycle <= cpu_pkg::UC_FETCH;
                    end else begin
                        pc     <= pc_inc;
                        ea     <= ea_abs;
                        am     <= 1'b1;
                        ucycle <= cpu_pkg::UC_EXEC;
                    end
                end
                cpu_pkg::UC_EXEC: begin
                    am <= 1'b0;                   // Back to PC for fetch
                    if (is_store) begin
                        wreq <= 1'b1;
                        dout <= store_data;
                    end
                    ucycle <= cpu_pkg::UC_FETCH;
                end
                cpu_pkg::UC_REL: begin
                    if (branch_taken) begin
                        pc     <= pc_rel;
                        ucycle <= (pc_rel[15:8] == pc_inc[15:8]) ? cpu_pkg::UC_REL_DONE
                                                                 : cpu_pkg::UC_REL_CROSS;
                    end else begin
                        pc     <= pc_inc;         // Skip offset
                        ucycle <= cpu_pkg::UC_FETCH;
                    end
                end
                cpu_pkg::UC_REL_CROSS: ucycle <= cpu_pkg::UC_REL_DONE;
                cpu_pkg::UC_REL_DONE:  ucycle <= cpu_pkg::UC_FETCH;
                cpu_pkg::UC_RST_LO: begin
                    tr     <= din;
                    pc     <= `CPU_RESET_VEC + 16'd1;
                    ucycle <= cpu_pkg::UC_RST_HI;
                end
                cpu_pkg::UC_RST_HI: begin
                    pc     <= ea_abs;             // Vector loaded
                    ucycle <= cpu_pkg::UC_RST_JMP;
                end
                cpu_pkg::UC_RST_JMP:   ucycle <= cpu_pkg::UC_FETCH;
                default:               ucycle <= cpu_pkg::UC_RST_LO;  // Illegal encoding
            endcase
        end
    end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
    input  wire                  CLK,
    input  wire                  RESET,
    input  wire cpu_pkg::byte_t  din,    // Same-cycle read data
    output wire cpu_pkg::addr_t  addr,   // Read address
    output wire cpu_pkg::addr_t  waddr,  // Write address
    output wire cpu_pkg::byte_t  dout,
    output wire                  wreq    // Write at next rising edge
);

    cpu_pkg::ucycle_e  ucycle;
    cpu_pkg::byte_t    opcode;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::reg_sel_t sel_a;
    cpu_pkg::reg_sel_t sel_b_reg;
    cpu_pkg::reg_sel_t wr_sel;
    cpu_pkg::reg_sel_t store_sel;
    logic              use_acc;
    logic              reg_we;
    logic              flag_we;
    logic              branch_taken;
    cpu_pkg::byte_t    opnd_a;
    cpu_pkg::byte_t    opnd_b;
    cpu_pkg::byte_t    result;
    cpu_pkg::byte_t    store_data;
    cpu_pkg::flags_t   flags;
    cpu_pkg::flags_t   flags_next;

    cpu_sequencer u_seq (
        .CLK(CLK), .RESET(RESET), .din(din), .branch_taken(branch_taken),
        .store_data(store_data), .ucycle(ucycle), .opcode(opcode),
        .addr(addr), .waddr(waddr), .dout(dout), .wreq(wreq)
    );

    cpu_decoder u_dec (
        .ucycle(ucycle), .opcode(opcode), .flags(flags), .alu_op(alu_op),
        .sel_a(sel_a), .sel_b_reg(sel_b_reg), .use_acc(use_acc), .reg_we(reg_we),
        .flag_we(flag_we), .wr_sel(wr_sel), .store_sel(store_sel),
        .branch_taken(branch_taken)
    );

    cpu_regfile u_regs (
        .CLK(CLK), .RESET(RESET), .din(din), .sel_a(sel_a), .sel_b_reg(sel_b_reg),
        .use_acc(use_acc), .reg_we(reg_we), .flag_we(flag_we), .wr_sel(wr_sel),
        .store_sel(store_sel), .result(result), .flags_next(flags_next),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .flags(flags), .store_data(store_data)
    );

    cpu_alu u_alu (
        .alu_op(alu_op), .opnd_a(opnd_a), .opnd_b(opnd_b), .flags(flags),
        .opcode_bit5(opcode[5]), .result(result), .flags_next(flags_next)
    );

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;

    localparam int LIMIT    = 400;  // About three times the program run
    localparam int N_STORES = 17;

    logic           CLK   = 1'b0;
    logic           RESET = 1'b1;
    cpu_pkg::byte_t mem [0:65535];  // 64 KB memory model
    cpu_pkg::byte_t din;
    cpu_pkg::addr_t addr;
    cpu_pkg::addr_t waddr;
    cpu_pkg::byte_t dout;
    logic           wreq;
    cpu_pkg::addr_t load_ptr;       // Next program byte
    int             cycles = 0;
    logic           done;

    cpu_top u_dut (
        .CLK(CLK), .RESET(RESET), .din(din), .addr(addr),
        .waddr(waddr), .dout(dout), .wreq(wreq)
    );

    always #20 CLK = ~CLK;          // 40 ns period

    assign din = mem[addr];         // Same-cycle read

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (wreq) mem[waddr] <= dout;
    end

    assign done = (u_dut.u_props.loop_hits >= 3) && (u_dut.u_props.store_idx == N_STORES);

    // Places one instruction of n bytes at load_ptr
    task automatic put_instr(input int n, input cpu_pkg::byte_t b0, input cpu_pkg::byte_t b1,
                             input cpu_pkg::byte_t b2);
        mem[load_ptr] = b0;
        if (n > 1) mem[load_ptr + 16'd1] = b1;
        if (n > 2) mem[load_ptr + 16'd2] = b2;
        load_ptr = load_ptr + 16'(n);
    endtask

    // ----------------------------------------------------------
    // Program image
    // ----------------------------------------------------------
    task automatic load_program();
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i ^ (i >> 8)) ^ 8'h5C;  // Fill from both address bytes
        end
        mem[16'hFFFC] = 8'h00;                  // Reset vector 0200
        mem[16'hFFFD] = 8'h02;
        load_ptr = 16'h0200;
        put_instr(2, 8'hA9, 8'h5A, 8'h00);   // LDA #5A
        put_instr(2, 8'h85, 8'h10, 8'h00);   // STA 10
        put_instr(2, 8'h29, 8'hF0, 8'h00);   // AND #F0
        put_instr(2, 8'h85, 8'h11, 8'h00);
        put_instr(2, 8'h09, 8'h0C, 8'h00);   // ORA #0C
        put_instr(2, 8'h85, 8'h12, 8'h00);
        put_instr(2, 8'h49, 8'hFF, 8'h00);   // EOR #FF
        put_instr(2, 8'h85, 8'h13, 8'h00);
        put_instr(1, 8'h18, 8'h00, 8'h00);   // CLC
        put_instr(2, 8'h69, 8'h25, 8'h00);   // ADC #25
        put_instr(2, 8'h85, 8'h14, 8'h00);
        put_instr(1, 8'h38, 8'h00, 8'h00);   // SEC
        put_instr(2, 8'hE9, 8'h48, 8'h00);   // SBC #48
        put_instr(2, 8'h85, 8'h15, 8'h00);
        put_instr(2, 8'h65, 8'h10, 8'h00);   // ADC 10 reads first store
        put_instr(2, 8'h85, 8'h16, 8'h00);
        put_instr(2, 8'hA2, 8'h7F, 8'h00);   // LDX #7F
        put_instr(1, 8'hE8, 8'h00, 8'h00);   // INX
        put_instr(3, 8'h8E, 8'h00, 8'h04);   // STX 0400
        put_instr(2, 8'hA0, 8'h03, 8'h00);   // LDY #03
        put_instr(1, 8'h88, 8'h00, 8'h00);   // DEY
        put_instr(3, 8'h8C, 8'h01, 8'h04);   // STY 0401
        put_instr(1, 8'hCA, 8'h00, 8'h00);   // DEX
        put_instr(1, 8'h8A, 8'h00, 8'h00);   // TXA
        put_instr(3, 8'h8D, 8'h02, 8'h04);   // STA 0402
        put_instr(1, 8'h98, 8'h00, 8'h00);   // TYA
        put_instr(3, 8'h8D, 8'h03, 8'h04);
        put_instr(1, 8'hAA, 8'h00, 8'h00);   // TAX
        put_instr(1, 8'hE8, 8'h00, 8'h00);   // INX
        put_instr(3, 8'h8E, 8'h04, 8'h04);   // STX 0404
        put_instr(3, 8'hAD, 8'h00, 8'h04);   // LDA 0400
        put_instr(3, 8'h8D, 8'h05, 8'h04);
        put_instr(1, 8'h38, 8'h00, 8'h00);   // SEC
        put_instr(2, 8'h90, 8'h02, 8'h00);   // BCC not taken
        put_instr(2, 8'h85, 8'h20, 8'h00);   // Marker stored
        put_instr(1, 8'h18, 8'h00, 8'h00);   // CLC
        put_instr(2, 8'h90, 8'h02, 8'h00);   // BCC taken
        put_instr(2, 8'h85, 8'h21, 8'h00);   // Marker skipped
        put_instr(2, 8'hC9, 8'h80, 8'h00);   // CMP #80 sets Z and C
        put_instr(2, 8'hF0, 8'h02, 8'h00);   // BEQ taken
        put_instr(2, 8'h85, 8'h22, 8'h00);   // Marker skipped
        put_instr(2, 8'hD0, 8'h02, 8'h00);   // BNE not taken
        put_instr(2, 8'h85, 8'h23, 8'h00);
        put_instr(2, 8'hC9, 8'h90, 8'h00);   // CMP #90 clears C and sets N
        put_instr(2, 8'hB0, 8'h02, 8'h00);   // BCS not taken
        put_instr(2, 8'h85, 8'h24, 8'h00);
        put_instr(3, 8'h4C, 8'hF0, 8'h02);   // JMP 02F0
        load_ptr = 16'h02F0;
        put_instr(2, 8'h30, 8'h10, 8'h00);   // BMI to 0302 across the page
        put_instr(2, 8'h85, 8'h25, 8'h00);   // Marker skipped
        load_ptr = 16'h0302;
        put_instr(2, 8'h85, 8'h26, 8'h00);
        put_instr(3, 8'h4C, 8'h04, 8'h03);   // JMP 0304 forever
    endtask

    initial begin
        load_program();
        repeat (10) @(posedge CLK);
        #2 RESET = 1'b0;
    end

    // ----------------------------------------------------------
    // Run control
    // ----------------------------------------------------------
    initial begin
        @(posedge CLK);
        while (u_dut.u_props.err_count == 0 && !done && cycles < LIMIT) @(posedge CLK);
        if (u_dut.u_props.err_count != 0) begin
            $display("FAIL %s expected %h actual %h", u_dut.u_props.fail_name,
                     u_dut.u_props.fail_exp, u_dut.u_props.fail_act);
            $display("TEST FAILED");
            $fatal(1, "Assertion failed in cpu_props");
        end else if (!done) begin
            $display("Timeout after %0d cycles without reaching the final loop", LIMIT);
            $display("TEST FAILED");
            $fatal(1, "Run did not complete");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
